// File: rtl/xgmii_pkg.sv
// XGMII bus widths, control characters and word types, referenced by scoped name from the rx stage, monitor and top
`default_nettype none

package xgmii_pkg;

	// bus geometry
	localparam int XGMII_LANES = 8;	// one byte lane per control bit
	localparam int LANE_W      = 8;	// bits per lane

	typedef logic [XGMII_LANES*LANE_W-1:0]  xgmii_data_t;	// txd/rxd, lane 0 in bits 7:0
	typedef logic [XGMII_LANES-1:0]         xgmii_ctrl_t;	// txc/rxc, bit n flags lane n as control
	typedef logic [$clog2(XGMII_LANES)-1:0] lane_idx_t;	// lane number 0..7

	// data and control always move together
	typedef struct packed {
		xgmii_data_t data;	// 64 bits
		xgmii_ctrl_t ctrl;	// 8 bits
	} xgmii_word_t;

	// control characters, only meaningful with the lane's ctrl bit set
	localparam logic [LANE_W-1:0] XGMII_IDLE  = 8'h07;	// /I/
	localparam logic [LANE_W-1:0] XGMII_START = 8'hFB;	// /S/
	localparam logic [LANE_W-1:0] XGMII_TERM  = 8'hFD;	// /T/

	// preamble bytes travel as plain data
	localparam logic [LANE_W-1:0] PREAMBLE_BYTE = 8'h55;
	localparam logic [LANE_W-1:0] SFD_BYTE      = 8'hD5;	// start frame delimiter

	// idle on every lane, sent between frames and while in reset
	localparam xgmii_word_t IDLE_WORD = '{
		data: {XGMII_LANES{XGMII_IDLE}},
		ctrl: {XGMII_LANES{1'b1}}
	};

	// decode results for one word, registered alongside the word
	typedef struct packed {
		logic      start0;	// /S/ in lane 0 with full preamble and SFD
		logic      start4;	// /S/ in lane 4, 55 55 55 in lanes 5..7
		logic      term;	// /T/ found with a legal ctrl pattern
		lane_idx_t term_lane;	// where the /T/ sits
		logic      start_1g;	// lane 0 holds control FB
		logic      term_1g;	// lane 0 holds control FD
	} word_flags_t;

endpackage

`default_nettype wire

// File: rtl/phy_mon_pkg.sv
// speed codes, frame monitor state, counter types and the per-frame report shared by the monitor and the top level
`default_nettype none

package phy_mon_pkg;

	// MAC speed select, codes not listed are reserved and behave as wide mode
	typedef enum logic [2:0] {
		SPEED_10G = 3'b000,
		SPEED_1G  = 3'b001,	// byte-wide, lane 0 only
		SPEED_2G5 = 3'b010,
		SPEED_5G  = 3'b101
	} fmac_speed_t;

	// frame tracking
	typedef enum logic {
		MON_IDLE,	// waiting for a start
		MON_FRAME	// between start and terminate
	} mon_state_t;

	// counter widths
	localparam int BYTE_CNT_W = 16;
	localparam int PKT_NO_W   = 16;

	typedef logic [BYTE_CNT_W-1:0] byte_cnt_t;	// bytes logged in one frame
	typedef logic [PKT_NO_W-1:0]   pkt_no_t;	// frame sequence number

	// per-word byte contributions
	localparam byte_cnt_t BYTES_FULL_WORD = 16'd8;	// lane-0 start or body word
	localparam byte_cnt_t BYTES_START4    = 16'd4;	// lanes 4..7 of a lane-4 start
	localparam byte_cnt_t BYTES_1G_WORD   = 16'd1;	// 1G mode logs lane 0 only

	localparam pkt_no_t PKT_NO_FIRST = 16'd1;	// numbering restarts here after reset

	// published once per finished frame, valid with pkt_done
	typedef struct packed {
		pkt_no_t   pkt_no;	// upper 16 bits
		byte_cnt_t byte_count;	// lower 16 bits
	} pkt_report_t;

endpackage

`default_nettype wire

// File: rtl/xgmii_rx_stage.sv
// receive register of the PHY emulator, picks MAC loopback or generator word and decodes start/terminate with it
`default_nettype none

module xgmii_rx_stage (
	input  wire                         x_clk,
	input  wire                         reset_,		// sync, active low
	input  wire                         rx_pkt_gen_sel,	// 1 = generator, 0 = loopback
	input  wire xgmii_pkg::xgmii_word_t xgmii_tx,		// MAC transmit word
	input  wire xgmii_pkg::xgmii_word_t gen_word,		// external packet generator
	output xgmii_pkg::xgmii_word_t      xgmii_rx,		// registered word to the MAC
	output xgmii_pkg::word_flags_t      rx_flags		// decode of the same word
);

	xgmii_pkg::xgmii_word_t  sel_word;	// word chosen this cycle
	xgmii_pkg::word_flags_t  dec_flags;	// its decode, registered with it

	// loopback or generator
	assign sel_word = rx_pkt_gen_sel ? gen_word : xgmii_tx;

	// decode runs on the selected word so flags and data land in the same register stage
	always_comb begin
		dec_flags = '0;

		// lane-0 start: D5 55 55 55 55 55 55 FB, lane 7 down to lane 0, only ctrl[0] set
		dec_flags.start0 = (sel_word.data == {xgmii_pkg::SFD_BYTE,
				{6{xgmii_pkg::PREAMBLE_BYTE}},
				xgmii_pkg::XGMII_START})
			&& (sel_word.ctrl == xgmii_pkg::xgmii_ctrl_t'(1));

		// lane-4 start, lanes 0..3 are don't care (previous frame tail or idle)
		dec_flags.start4 = (sel_word.data[4*xgmii_pkg::LANE_W +: 4*xgmii_pkg::LANE_W]
				== {{3{xgmii_pkg::PREAMBLE_BYTE}}, xgmii_pkg::XGMII_START})
			&& (sel_word.ctrl[7:4] == 4'b0001);

		// terminate in lane t: FD there, ctrl set from t upward and clear below
		for (int t = 0; t < xgmii_pkg::XGMII_LANES; t++) begin
			if ((sel_word.data[t*xgmii_pkg::LANE_W +: xgmii_pkg::LANE_W]
					== xgmii_pkg::XGMII_TERM)
					&& (sel_word.ctrl == ({xgmii_pkg::XGMII_LANES{1'b1}} << t))) begin
				dec_flags.term      = 1'b1;
				dec_flags.term_lane = xgmii_pkg::lane_idx_t'(t);	// ctrl pattern is unique per lane
			end
		end

		// 1G mode looks at lane 0 alone
		dec_flags.start_1g = sel_word.ctrl[0]
			&& (sel_word.data[xgmii_pkg::LANE_W-1:0] == xgmii_pkg::XGMII_START);
		dec_flags.term_1g  = sel_word.ctrl[0]
			&& (sel_word.data[xgmii_pkg::LANE_W-1:0] == xgmii_pkg::XGMII_TERM);
	end

	// one register stage, idle pattern while in reset
	always_ff @(posedge x_clk) begin
		if (!reset_) begin
			xgmii_rx <= xgmii_pkg::IDLE_WORD;	// all lanes /I/, all ctrl set
			rx_flags <= '0;				// no start or terminate pending
		end else begin
			xgmii_rx <= sel_word;
			rx_flags <= dec_flags;
		end
	end

endmodule

`default_nettype wire

// File: rtl/frame_monitor.sv
// frame monitor that tracks frames on the registered receive word, counts logged bytes and reports each finished frame
`default_nettype none

module frame_monitor (
	input  wire                          x_clk,
	input  wire                          reset_,	// sync, active low
	input  wire phy_mon_pkg::fmac_speed_t fmac_speed,	// 001 = 1G, rest wide
	input  wire xgmii_pkg::xgmii_word_t  xgmii_rx,	// registered receive word
	input  wire xgmii_pkg::word_flags_t  rx_flags,	// decode aligned to xgmii_rx
	output logic                         vld_data_flag,	// high while a frame is in progress
	output logic                         pkt_done,	// one-cycle pulse per finished frame
	output phy_mon_pkg::pkt_report_t     pkt_report	// valid with pkt_done
);

	phy_mon_pkg::mon_state_t state;
	phy_mon_pkg::pkt_no_t    pkt_num;	// number of the frame in progress
	phy_mon_pkg::byte_cnt_t  byte_cnt;	// bytes logged before this word
	phy_mon_pkg::byte_cnt_t  word_bytes;	// bytes this word adds

	logic mode_1g;		// lane-0 monitoring
	logic start_hit;	// start matching the speed mode
	logic term_hit;		// terminate matching the speed mode

	// reserved codes fall back to wide monitoring
	assign mode_1g = (fmac_speed == phy_mon_pkg::SPEED_1G);

	// only lane-0 and lane-4 starts open a frame in wide mode
	assign start_hit = mode_1g ? rx_flags.start_1g : (rx_flags.start0 || rx_flags.start4);

	assign term_hit = mode_1g ? rx_flags.term_1g : rx_flags.term;

	// bytes contributed by the current word
	always_comb begin
		if (mode_1g) begin
			word_bytes = phy_mon_pkg::BYTES_1G_WORD;	// one byte per word from start to end
		end else if (state == phy_mon_pkg::MON_IDLE) begin
			word_bytes = rx_flags.start4 ? phy_mon_pkg::BYTES_START4
				: phy_mon_pkg::BYTES_FULL_WORD;
		end else if (term_hit) begin
			word_bytes = phy_mon_pkg::byte_cnt_t'(rx_flags.term_lane) + 16'd1;	// lanes 0..t
		end else begin
			word_bytes = phy_mon_pkg::BYTES_FULL_WORD;	// body word
		end
	end

	// frame FSM, packet numbering and the done pulse
	always_ff @(posedge x_clk) begin
		if (!reset_) begin
			state    <= phy_mon_pkg::MON_IDLE;
			pkt_num  <= phy_mon_pkg::PKT_NO_FIRST;
			pkt_done <= 1'b0;
		end else begin
			pkt_done <= 1'b0;	// pulse by default low
			case (state)
				phy_mon_pkg::MON_IDLE: begin
					if (start_hit) begin
						state <= phy_mon_pkg::MON_FRAME;
					end
				end
				phy_mon_pkg::MON_FRAME: begin
					if (term_hit) begin
						state    <= phy_mon_pkg::MON_IDLE;
						pkt_done <= 1'b1;	// same cycle vld_data_flag drops
						pkt_num  <= pkt_num + 16'd1;
					end
				end
				default: begin
					state <= phy_mon_pkg::MON_IDLE;
				end
			endcase
		end
	end

	// byte accumulation and report capture
	always_ff @(posedge x_clk) begin
		if (state == phy_mon_pkg::MON_IDLE) begin
			byte_cnt <= word_bytes;	// start word seeds the count
		end else begin
			byte_cnt <= byte_cnt + word_bytes;
		end

		if ((state == phy_mon_pkg::MON_FRAME) && term_hit) begin
			pkt_report <= '{pkt_no: pkt_num, byte_count: byte_cnt + word_bytes};	// includes terminate
		end
	end

	// high one cycle after the start word reaches xgmii_rx
	assign vld_data_flag = (state == phy_mon_pkg::MON_FRAME);

endmodule

`default_nettype wire

// File: rtl/phy_emulator_top.sv
// top of the XGMII PHY emulator receive side, rx register stage feeding the frame monitor
`default_nettype none

module phy_emulator_top (
	input  wire                           x_clk,
	input  wire                           reset_,		// sync, active low
	input  wire phy_mon_pkg::fmac_speed_t fmac_speed,	// 001 = 1G, others wide
	input  wire                           rx_pkt_gen_sel,	// 1 = generator, 0 = loopback
	input  wire xgmii_pkg::xgmii_word_t   xgmii_tx,		// MAC transmit side
	input  wire xgmii_pkg::xgmii_word_t   gen_word,		// external packet generator
	output xgmii_pkg::xgmii_word_t        xgmii_rx,		// to the MAC receive side
	output logic                          vld_data_flag,	// frame in progress
	output logic                          pkt_done,		// frame finished, one cycle
	output phy_mon_pkg::pkt_report_t      pkt_report	// number and byte count
);

	// decode of xgmii_rx, same cycle as the word
	wire xgmii_pkg::word_flags_t rx_flags;

	// inputs to xgmii_rx and rx_flags, one cycle
	xgmii_rx_stage u_rx_stage (
		.x_clk          (x_clk),
		.reset_         (reset_),
		.rx_pkt_gen_sel (rx_pkt_gen_sel),
		.xgmii_tx       (xgmii_tx),
		.gen_word       (gen_word),
		.xgmii_rx       (xgmii_rx),
		.rx_flags       (rx_flags)
	);

	// flags to vld_data_flag and pkt_done, one more cycle
	frame_monitor u_frame_monitor (
		.x_clk         (x_clk),
		.reset_        (reset_),
		.fmac_speed    (fmac_speed),
		.xgmii_rx      (xgmii_rx),
		.rx_flags      (rx_flags),
		.vld_data_flag (vld_data_flag),
		.pkt_done      (pkt_done),
		.pkt_report    (pkt_report)
	);

endmodule

`default_nettype wire

// File: test/rx_checker.sv
// result checker for the PHY emulator testbench, follows the applied lines and compares the UUT outputs
`default_nettype none

module rx_checker (
	input  wire                           x_clk,
	input  wire                           reset_,		// as driven to the UUT
	input  wire                           rx_pkt_gen_sel,
	input  wire xgmii_pkg::xgmii_word_t   xgmii_tx,
	input  wire xgmii_pkg::xgmii_word_t   gen_word,
	input  wire xgmii_pkg::xgmii_word_t   xgmii_rx,		// UUT outputs from here
	input  wire                           vld_data_flag,
	input  wire                           pkt_done,
	input  wire phy_mon_pkg::pkt_report_t pkt_report,
	input  wire                           line_valid,		// a file line is on the inputs
	input  wire                           end_of_stim,	// no more lines coming
	input  wire [3:0]                     test_no,
	input  wire                           exp_in_frame,
	input  wire                           exp_done,
	input  wire phy_mon_pkg::pkt_report_t exp_report,
	output int                            error_count,
	output int                            test_count,
	output logic                          all_done
);

	localparam int MAX_TESTS = 16;

	// one applied line, as it moves down the delay line
	typedef struct packed {
		logic                     valid;	// holds a file line
		logic                     in_reset;	// reset_ low on this line
		logic [3:0]               test_no;
		xgmii_pkg::xgmii_word_t   word;	// word on the selected input
		logic                     in_frame;	// frame open after this word
		logic                     done;	// this word ends a frame
		phy_mon_pkg::pkt_report_t report;
	} entry_t;

	entry_t     d1;		// applied one cycle ago, due on xgmii_rx
	entry_t     d2;		// two cycles ago, due on the monitor outputs
	int         test_errors [MAX_TESTS];
	logic [3:0] open_test;	// test still having lines in the pipe

	initial begin
		d1 = '0;
		d2 = '0;
		error_count = 0;
		test_count = 0;
		all_done = 1'b0;
		open_test = 4'd0;
		foreach (test_errors[i]) begin
			test_errors[i] = 0;
		end
	end

	task automatic flag_mismatch(input string sig, input logic [71:0] exp_val,
			input logic [71:0] got_val, input logic [3:0] t);
		$display("Mismatch at %0t: %s expected %0h got %0h", $time, sig, exp_val, got_val);
		error_count++;
		test_errors[t]++;
	endtask

	// one line per finished test
	task automatic close_test(input logic [3:0] t);
		$display("test %0d done, %0d error(s)", t, test_errors[t]);
		test_count++;
	endtask

	// negedge sampling, all UUT outputs settled since the last rising edge
	always @(negedge x_clk) begin
		entry_t                 e_now;
		xgmii_pkg::xgmii_word_t exp_rx;
		logic                   held;	// reset in the last two lines clears the monitor

		if (!all_done) begin
			if (d1.valid) begin
				exp_rx = d1.in_reset ? xgmii_pkg::IDLE_WORD : d1.word;	// rx stage is one cycle
				if (xgmii_rx !== exp_rx) begin
					flag_mismatch("xgmii_rx", exp_rx, xgmii_rx, d1.test_no);
				end
			end

			if (d2.valid) begin
				held = d1.in_reset || d2.in_reset;
				if (vld_data_flag !== (d2.in_frame && !held)) begin
					flag_mismatch("vld_data_flag", 72'(d2.in_frame && !held),
						72'(vld_data_flag), d2.test_no);
				end
				if (pkt_done !== (d2.done && !held)) begin
					flag_mismatch("pkt_done", 72'(d2.done && !held), 72'(pkt_done),
						d2.test_no);
				end
				if (d2.done && !held && (pkt_done === 1'b1)) begin	// report valid with the pulse
					if (pkt_report.pkt_no !== d2.report.pkt_no) begin
						flag_mismatch("pkt_report.pkt_no", 72'(d2.report.pkt_no),
							72'(pkt_report.pkt_no), d2.test_no);
					end
					if (pkt_report.byte_count !== d2.report.byte_count) begin
						flag_mismatch("pkt_report.byte_count", 72'(d2.report.byte_count),
							72'(pkt_report.byte_count), d2.test_no);
					end
				end
				if (d2.test_no != open_test) begin	// previous test fully checked
					if (open_test != 4'd0) begin
						close_test(open_test);
					end
					open_test = d2.test_no;
				end
			end else if (end_of_stim && !d1.valid) begin
				if (open_test != 4'd0) begin
					close_test(open_test);
				end
				all_done = 1'b1;
			end

			// capture the line now on the inputs
			e_now = '0;
			if (line_valid) begin
				e_now.valid    = 1'b1;
				e_now.in_reset = !reset_;
				e_now.test_no  = test_no;
				e_now.word     = rx_pkt_gen_sel ? gen_word : xgmii_tx;
				e_now.in_frame = exp_in_frame;
				e_now.done     = exp_done;
				e_now.report   = exp_report;
			end
			d2 = d1;
			d1 = e_now;
		end
	end

endmodule

`default_nettype wire

// File: test/phy_emulator_tb.sv
// testbench top that replays the stimulus file into the PHY emulator receive side and prints the result
`default_nettype none

module phy_emulator_tb;

	localparam int CLK_PERIOD     = 100;
	localparam int MAX_LINES      = 64;
	localparam int WATCHDOG_SLACK = 20;	// cycles beyond the file length

	// one line of the stimulus file
	typedef struct packed {
		logic [3:0]               test_no;
		logic                     rst_level;	// value for reset_
		logic                     sel;
		logic [2:0]               speed;
		logic                     rnd;		// filler replaces the data
		xgmii_pkg::xgmii_word_t   word;
		logic                     in_frame;
		logic                     done;
		phy_mon_pkg::pkt_report_t report;
	} stim_line_t;

	logic                     x_clk;
	logic                     reset_;
	phy_mon_pkg::fmac_speed_t fmac_speed;
	logic                     rx_pkt_gen_sel;
	xgmii_pkg::xgmii_word_t   xgmii_tx;
	xgmii_pkg::xgmii_word_t   gen_word;
	xgmii_pkg::xgmii_word_t   xgmii_rx;
	logic                     vld_data_flag;
	logic                     pkt_done;
	phy_mon_pkg::pkt_report_t pkt_report;

	// expected columns of the line on the inputs
	logic                     line_valid;
	logic                     end_of_stim;
	logic [3:0]               test_no;
	logic                     exp_in_frame;
	logic                     exp_done;
	phy_mon_pkg::pkt_report_t exp_report;

	int          error_count;
	int          test_count;
	logic        all_done;
	stim_line_t  stim [MAX_LINES];
	int          n_lines;
	logic        loaded = 1'b0;
	logic [63:0] rnd_state;		// xorshift state

	initial x_clk = 1'b0;
	always #(CLK_PERIOD / 2) x_clk = ~x_clk;

	phy_emulator_top UUT (
		.x_clk          (x_clk),
		.reset_         (reset_),
		.fmac_speed     (fmac_speed),
		.rx_pkt_gen_sel (rx_pkt_gen_sel),
		.xgmii_tx       (xgmii_tx),
		.gen_word       (gen_word),
		.xgmii_rx       (xgmii_rx),
		.vld_data_flag  (vld_data_flag),
		.pkt_done       (pkt_done),
		.pkt_report     (pkt_report)
	);

	rx_checker u_rx_checker (
		.x_clk          (x_clk),
		.reset_         (reset_),
		.rx_pkt_gen_sel (rx_pkt_gen_sel),
		.xgmii_tx       (xgmii_tx),
		.gen_word       (gen_word),
		.xgmii_rx       (xgmii_rx),
		.vld_data_flag  (vld_data_flag),
		.pkt_done       (pkt_done),
		.pkt_report     (pkt_report),
		.line_valid     (line_valid),
		.end_of_stim    (end_of_stim),
		.test_no        (test_no),
		.exp_in_frame   (exp_in_frame),
		.exp_done       (exp_done),
		.exp_report     (exp_report),
		.error_count    (error_count),
		.test_count     (test_count),
		.all_done       (all_done)
	);

	function automatic logic [63:0] xorshift64(input logic [63:0] s);
		logic [63:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 7);
		x = x ^ (x << 17);
		return x;
	endfunction

	// next 64-bit filler from the xorshift state
	function automatic logic [63:0] next_filler();
		rnd_state = xorshift64(rnd_state);
		return rnd_state;
	endfunction

	task automatic load_stimulus(output logic ok);
		int          fd;
		int          got;
		string       text;
		int          t_no, rst, sel, rnd, frame, done, pkt, cnt;
		logic [2:0]  spd;
		logic [63:0] data;
		logic [7:0]  ctrl;
		fd = $fopen("test/phy_stimulus.txt", "r");
		ok = (fd != 0);
		n_lines = 0;
		if (ok) begin
			while (!$feof(fd) && (n_lines < MAX_LINES)) begin
				got = $fgets(text, fd);
				if ((got > 1) && (text.getc(0) != "#")) begin	// skip blanks and comments
					got = $sscanf(text, "%d %d %d %b %d %h %h %d %d %d %d", t_no, rst, sel,
						spd, rnd, data, ctrl, frame, done, pkt, cnt);
					if (got == 11) begin
						stim[n_lines].test_no           = t_no[3:0];
						stim[n_lines].rst_level         = rst[0];
						stim[n_lines].sel               = sel[0];
						stim[n_lines].speed             = spd;
						stim[n_lines].rnd               = rnd[0];
						stim[n_lines].word.data         = data;
						stim[n_lines].word.ctrl         = ctrl;
						stim[n_lines].in_frame          = frame[0];
						stim[n_lines].done              = done[0];
						stim[n_lines].report.pkt_no     = pkt[15:0];
						stim[n_lines].report.byte_count = cnt[15:0];
						n_lines++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// drives the file word on the selected input and filler on the other
	task automatic apply_line(input stim_line_t s);
		xgmii_pkg::xgmii_word_t picked;
		xgmii_pkg::xgmii_word_t other;
		logic [63:0]            fill;
		picked = s.word;
		if (s.rnd) begin
			picked.data = next_filler();
			picked.ctrl = '0;	// plain data never decodes as a start or terminate
		end
		other.data = next_filler();
		fill = next_filler();
		other.ctrl = fill[7:0];
		reset_         <= s.rst_level;
		fmac_speed     <= phy_mon_pkg::fmac_speed_t'(s.speed);
		rx_pkt_gen_sel <= s.sel;
		xgmii_tx       <= s.sel ? other : picked;
		gen_word       <= s.sel ? picked : other;
		line_valid     <= 1'b1;
		test_no        <= s.test_no;
		exp_in_frame   <= s.in_frame;
		exp_done       <= s.done;
		exp_report     <= s.report;
	endtask

	initial begin
		int   i;
		logic ok;
		reset_ = 1'b0;
		fmac_speed = phy_mon_pkg::SPEED_10G;
		rx_pkt_gen_sel = 1'b0;
		xgmii_tx = xgmii_pkg::IDLE_WORD;
		gen_word = xgmii_pkg::IDLE_WORD;
		line_valid = 1'b0;
		end_of_stim = 1'b0;
		test_no = 4'd0;
		exp_in_frame = 1'b0;
		exp_done = 1'b0;
		exp_report = '0;
		rnd_state = 64'd39;
		load_stimulus(ok);
		if (!ok) begin
			$display("cannot open test/phy_stimulus.txt, no stimulus to apply");
			$display("TEST FAIL");
			$finish;
		end else begin
			loaded = 1'b1;
			for (i = 0; i < n_lines; i++) begin
				@(posedge x_clk);
				apply_line(stim[i]);
			end
			@(posedge x_clk);
			line_valid  <= 1'b0;
			end_of_stim <= 1'b1;	// checker drains its delay line
			wait (all_done);
			$display("%0d tests, %0d errors", test_count, error_count);
			if ((error_count == 0) && (test_count > 0)) begin
				$display("TEST PASS");
			end else begin
				$display("TEST FAIL");
			end
			$finish;
		end
	end

	// watchdog sized from the file length
	initial begin
		wait (loaded);
		#((n_lines + WATCHDOG_SLACK) * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, the checker never finished",
			n_lines + WATCHDOG_SLACK);
		$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
rtl/xgmii_pkg.sv
rtl/phy_mon_pkg.sv
rtl/xgmii_rx_stage.sv
rtl/frame_monitor.sv
rtl/phy_emulator_top.sv
test/rx_checker.sv
test/phy_emulator_tb.sv

// File: run.sh
#!/bin/sh
# builds the PHY emulator testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module phy_emulator_tb -f compile.f -o phy_emulator_sim

out=$(./obj_dir/phy_emulator_sim)
echo "$out"

# the run passes only if the testbench printed its pass line
echo "$out" | grep -qx "TEST PASS"

// File: test/phy_stimulus.txt
# test reset_ sel speed(bin) rnd data(hex) ctrl(hex) in_frame done pkt_no bytes
# rnd=1 puts xorshift filler on the selected word with ctrl clear; in_frame is the state after the word
1 0 1 000 0 d5555555555555fb 01 0 0 0 0
1 0 0 000 0 d5555555555555fb 01 0 0 0 0
1 1 0 000 0 0707070707070707 ff 0 0 0 0
2 1 0 000 0 0123456789abcdef 00 0 0 0 0
2 1 1 000 0 1122334455667788 5a 0 0 0 0
2 1 1 000 1 0000000000000000 00 0 0 0 0
3 1 0 000 0 d5555555555555fb 01 1 0 0 0
3 1 0 000 1 0000000000000000 00 1 0 0 0
3 1 0 000 1 0000000000000000 00 1 0 0 0
3 1 0 000 1 0000000000000000 00 1 0 0 0
3 1 0 000 0 0707fd4433221100 e0 0 1 1 38
3 1 0 000 0 0707070707070707 ff 0 0 0 0
4 1 1 101 0 0707070707070707 ff 0 0 0 0
4 1 1 101 0 555555fb07070707 1f 1 0 0 0
4 1 1 101 0 07070707070707fd ff 0 1 2 5
4 1 1 101 0 5555555555fb0707 07 0 0 0 0
4 1 1 101 0 07070707fd221100 f8 0 0 0 0
4 1 1 101 0 0707070707070707 ff 0 0 0 0
5 1 0 001 0 0707070707070707 ff 0 0 0 0
5 1 0 001 0 07070707070707fb ff 1 0 0 0
5 1 0 001 1 0000000000000000 00 1 0 0 0
5 1 0 001 1 0000000000000000 00 1 0 0 0
5 1 0 001 1 0000000000000000 00 1 0 0 0
5 1 0 001 1 0000000000000000 00 1 0 0 0
5 1 0 001 1 0000000000000000 00 1 0 0 0
5 1 0 001 1 0000000000000000 00 1 0 0 0
5 1 0 001 0 07070707070707fd ff 0 1 3 8
5 1 0 001 0 0707070707070707 ff 0 0 0 0
6 1 1 000 0 0707070707070707 ff 0 0 0 0
6 1 1 000 0 d5555555555555fb 01 1 0 0 0
6 1 1 000 1 0000000000000000 00 1 0 0 0
6 0 1 000 1 0000000000000000 00 0 0 0 0
6 0 1 000 1 0000000000000000 00 0 0 0 0
6 1 1 000 0 0707070707070707 ff 0 0 0 0
6 1 1 000 0 d5555555555555fb 01 1 0 0 0
6 1 1 000 1 0000000000000000 00 1 0 0 0
6 1 1 000 0 fd66554433221100 80 0 1 1 24
6 1 1 000 0 0707070707070707 ff 0 0 0 0
